/* dma_pkg.sv */
// shared sizes, bus structs and enums for the DMA test subsystem
// every RTL block pulls this in with a wildcard import in its header

package dma_pkg;

	//////////////////////////////
	// sizes
	//////////////////////////////

	// data bus word, bytes per word
	localparam int DATA_WIDTH = 64;
	localparam int BYTES_PER_WORD = DATA_WIDTH / 8;
	// word address, top bit picks the slave (0 ram, 1 checker)
	localparam int WORD_AW = 10;
	// scratch ram depth and its index width
	localparam int RAM_WORDS = 64;
	localparam int RAM_AW = $clog2(RAM_WORDS);
	// transfer length in words
	localparam int LEN_WIDTH = 10;
	// host bus data width
	localparam int HB_DATA_WIDTH = 32;
	// checker shift register, taps on the two top bits
	localparam int LFSR_WIDTH = 32;
	localparam logic [LFSR_WIDTH-1:0] LFSR_POLY = 32'hc000_0000;
	// checker byte counters
	localparam int CNT_WIDTH = 12;

	//////////////////////////////
	// bus structs
	//////////////////////////////

	// data bus request, master to slave
	typedef struct packed {
		logic stb;
		logic we;
		logic [WORD_AW-1:0] addr;
		logic [DATA_WIDTH-1:0] data;
	} wb_req_t;

	// data bus response, read data valid with ack
	typedef struct packed {
		logic ack;
		logic [DATA_WIDTH-1:0] data;
	} wb_rsp_t;

	// host bus request
	typedef struct packed {
		logic stb;
		logic we;
		logic [1:0] addr;
		logic [HB_DATA_WIDTH-1:0] data;
		logic [3:0] sel;
	} hb_req_t;

	// host bus response
	typedef struct packed {
		logic ack;
		logic [HB_DATA_WIDTH-1:0] data;
	} hb_rsp_t;

	// DMA register map
	typedef enum logic [1:0] {
		REG_SRC  = 2'd0,
		REG_DST  = 2'd1,
		REG_LEN  = 2'd2,
		REG_CTRL = 2'd3
	} dma_reg_e;

	// mover states
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		READ  = 2'd1,
		WRITE = 2'd2
	} mover_state_e;

endpackage

/* lfsr_checker.sv */
// LFSR pattern source and sink on the data bus
// reads return the pseudo-random stream, writes are checked against it
// a 32-bit status port seeds the LFSR and reports counts and the error flag

`timescale 1ns/10ps

module lfsr_checker
	import dma_pkg::*;
(
	input  logic    i_clk,
	input  logic    i_reset,
	input  wb_req_t i_wb_req,
	output wb_rsp_t o_wb_rsp,
	input  hb_req_t i_st_req,
	output hb_rsp_t o_st_rsp
);

	// 32 shifts, each feeding back the parity of the tapped bits
	function automatic logic [LFSR_WIDTH-1:0] advance_lfsr(
		input logic [LFSR_WIDTH-1:0] istate
	);
		logic [LFSR_WIDTH-1:0] fill;
		int k;
		fill = istate;
		for (k = 0; k < LFSR_WIDTH; k++)
			fill = {fill[LFSR_WIDTH-2:0], ^(fill & LFSR_POLY)};
		return fill;
	endfunction

	logic [LFSR_WIDTH-1:0] lfsr_state;
	logic [LFSR_WIDTH-1:0] mid_state;
	logic [LFSR_WIDTH-1:0] next_state;
	logic [DATA_WIDTH-1:0] exp_word;

	logic rd_en;
	logic wr_en;
	logic seed_wr;
	logic st_rd;

	logic [CNT_WIDTH-1:0] rd_count;
	logic [CNT_WIDTH-1:0] wr_count;
	logic err_flag;

	logic wb_ack_q;
	logic [DATA_WIDTH-1:0] wb_data_q;
	logic st_ack_q;
	logic [HB_DATA_WIDTH-1:0] st_data_q;

	//////////////////////////////
	// pattern stream
	//////////////////////////////

	// word at the current state: state on top, state+32 shifts below
	assign mid_state  = advance_lfsr(lfsr_state);
	assign next_state = advance_lfsr(mid_state);
	assign exp_word   = {lfsr_state, mid_state};

	// decoded accesses
	assign rd_en   = i_wb_req.stb && !i_wb_req.we;
	assign wr_en   = i_wb_req.stb && i_wb_req.we;
	assign seed_wr = i_st_req.stb && i_st_req.we && (i_st_req.sel != 4'h0);
	assign st_rd   = i_st_req.stb && !i_st_req.we;

	// state update, seed loads win over a data access
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			lfsr_state <= '0;
		else if (seed_wr)
		begin
			for (int b = 0; b < 4; b++)
				if (i_st_req.sel[b])
					lfsr_state[8*b +: 8] <= i_st_req.data[8*b +: 8];
		end
		else if (rd_en || wr_en)
			// one word is 64 shifts
			lfsr_state <= next_state;
	end

	//////////////////////////////
	// counters and error flag
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			rd_count <= '0;
			wr_count <= '0;
			err_flag <= 1'b0;
		end
		else if (seed_wr)
		begin
			// new test, start from clean counts
			rd_count <= '0;
			wr_count <= '0;
			err_flag <= 1'b0;
		end
		else
		begin
			// counts are in bytes
			if (rd_en)
				rd_count <= rd_count + CNT_WIDTH'(BYTES_PER_WORD);
			if (wr_en)
				wr_count <= wr_count + CNT_WIDTH'(BYTES_PER_WORD);
			// sticky until the next seed
			if (wr_en && (i_wb_req.data != exp_word))
				err_flag <= 1'b1;
		end
	end

	//////////////////////////////
	// bus responses
	//////////////////////////////

	// data bus ack, one cycle after each strobe
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			wb_ack_q <= 1'b0;
		else
			wb_ack_q <= i_wb_req.stb;
	end

	// read word lands with the ack
	always_ff @(posedge i_clk)
	begin
		if (rd_en)
			wb_data_q <= exp_word;
	end

	// status port ack
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			st_ack_q <= 1'b0;
		else
			st_ack_q <= i_st_req.stb;
	end

	// status read mux, bit 0 of the address only
	always_ff @(posedge i_clk)
	begin
		if (st_rd)
		begin
			if (i_st_req.addr[0])
				st_data_q <= lfsr_state;
			else
				st_data_q <= {wr_count, 4'h0, rd_count, 3'h0, err_flag};
		end
	end

	assign o_wb_rsp.ack  = wb_ack_q;
	assign o_wb_rsp.data = wb_data_q;
	assign o_st_rsp.ack  = st_ack_q;
	assign o_st_rsp.data = st_data_q;

endmodule

/* scratch_ram.sv */
// word-wide scratch RAM on the data bus
// indexed by the low address bits, acks one cycle after every strobe

`timescale 1ns/10ps

module scratch_ram
	import dma_pkg::*;
(
	input  logic    i_clk,
	input  logic    i_reset,
	input  wb_req_t i_req,
	output wb_rsp_t o_rsp
);

	logic [DATA_WIDTH-1:0] mem [RAM_WORDS];
	logic [RAM_AW-1:0] idx;
	logic ack_q;
	logic [DATA_WIDTH-1:0] rd_data_q;

	// upper address bits belong to the slave decode
	assign idx = i_req.addr[RAM_AW-1:0];

	// write port and registered read
	always_ff @(posedge i_clk)
	begin
		if (i_req.stb && i_req.we)
			mem[idx] <= i_req.data;
		if (i_req.stb && !i_req.we)
			rd_data_q <= mem[idx];
	end

	// single cycle ack
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			ack_q <= 1'b0;
		else
			ack_q <= i_req.stb;
	end

	assign o_rsp.ack  = ack_q;
	assign o_rsp.data = rd_data_q;

endmodule

/* bus_slave_mux.sv */
// data bus decode between the scratch RAM and the checker
// address top bit picks the slave, response taken from whichever acks

`timescale 1ns/10ps

module bus_slave_mux
	import dma_pkg::*;
(
	input  wb_req_t i_req,
	output wb_rsp_t o_rsp,
	output wb_req_t o_ram_req,
	input  wb_rsp_t i_ram_rsp,
	output wb_req_t o_chk_req,
	input  wb_rsp_t i_chk_rsp
);

	logic chk_sel;

	// 0 ram, 1 checker
	assign chk_sel = i_req.addr[WORD_AW-1];

	always_comb
	begin
		// same request to both, strobe only where selected
		o_ram_req     = i_req;
		o_ram_req.stb = i_req.stb && !chk_sel;
		o_chk_req     = i_req;
		o_chk_req.stb = i_req.stb && chk_sel;
		// one request in flight, so at most one ack
		if (i_chk_rsp.ack)
			o_rsp = i_chk_rsp;
		else
			o_rsp = i_ram_rsp;
	end

endmodule

/* dma_mover.sv */
// single channel word mover
// reads one word at the source, writes it at the destination, repeats
// 4 cycles per word, busy high for the whole block

`timescale 1ns/10ps

module dma_mover
	import dma_pkg::*;
(
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  logic                 i_start,
	input  logic [WORD_AW-1:0]   i_src,
	input  logic [WORD_AW-1:0]   i_dst,
	input  logic [LEN_WIDTH-1:0] i_len,
	output logic                 o_busy,
	output wb_req_t              o_req,
	input  wb_rsp_t              i_rsp
);

	mover_state_e state;
	logic [LEN_WIDTH-1:0] remain_q;
	logic req_stb;
	logic req_we;

	logic [WORD_AW-1:0] src_q;
	logic [WORD_AW-1:0] dst_q;
	logic [DATA_WIDTH-1:0] data_q;

	//////////////////////////////
	// control FSM
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state    <= IDLE;
			remain_q <= '0;
			req_stb  <= 1'b0;
			req_we   <= 1'b0;
		end
		else
		begin
			// strobe is a single cycle pulse
			req_stb <= 1'b0;
			case (state)
			IDLE:
				// zero length never leaves idle
				if (i_start && (i_len != '0))
				begin
					state    <= READ;
					remain_q <= i_len;
					req_stb  <= 1'b1;
					req_we   <= 1'b0;
				end
			READ:
				// word is back, write it out
				if (i_rsp.ack)
				begin
					state   <= WRITE;
					req_stb <= 1'b1;
					req_we  <= 1'b1;
				end
			WRITE:
				if (i_rsp.ack)
				begin
					remain_q <= remain_q - 1'b1;
					if (remain_q == LEN_WIDTH'(1))
						state <= IDLE;
					else
					begin
						// next word
						state   <= READ;
						req_stb <= 1'b1;
						req_we  <= 1'b0;
					end
				end
			default:
				state <= IDLE;
			endcase
		end
	end

	//////////////////////////////
	// addresses and data
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if ((state == IDLE) && i_start)
		begin
			src_q <= i_src;
			dst_q <= i_dst;
		end
		// hold the read word for the write
		if ((state == READ) && i_rsp.ack)
			data_q <= i_rsp.data;
		// step both after each written word
		if ((state == WRITE) && i_rsp.ack)
		begin
			src_q <= src_q + 1'b1;
			dst_q <= dst_q + 1'b1;
		end
	end

	assign o_busy = (state != IDLE);

	assign o_req.stb  = req_stb;
	assign o_req.we   = req_we;
	assign o_req.addr = req_we ? dst_q : src_q;
	assign o_req.data = data_q;

endmodule

/* dma_regs.sv */
// host visible DMA registers: source, destination, length, control
// a control write starts the mover, control reads give busy and done

`timescale 1ns/10ps

module dma_regs
	import dma_pkg::*;
(
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  hb_req_t               i_req,
	output hb_rsp_t               o_rsp,
	output logic                  o_start,
	output logic [WORD_AW-1:0]    o_src,
	output logic [WORD_AW-1:0]    o_dst,
	output logic [LEN_WIDTH-1:0]  o_len,
	input  logic                  i_busy
);

	dma_reg_e addr;
	logic wr;
	logic rd;
	logic busy_q;
	logic done_q;
	logic ack_q;
	logic [HB_DATA_WIDTH-1:0] rd_data_q;

	assign addr = dma_reg_e'(i_req.addr);
	assign wr   = i_req.stb && i_req.we;
	assign rd   = i_req.stb && !i_req.we;

	// register writes, start pulse and done tracking
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_src   <= '0;
			o_dst   <= '0;
			o_len   <= '0;
			o_start <= 1'b0;
			busy_q  <= 1'b0;
			done_q  <= 1'b0;
		end
		else
		begin
			busy_q <= i_busy;
			if (wr && (addr == REG_SRC))
				o_src <= i_req.data[WORD_AW-1:0];
			if (wr && (addr == REG_DST))
				o_dst <= i_req.data[WORD_AW-1:0];
			if (wr && (addr == REG_LEN))
				o_len <= i_req.data[LEN_WIDTH-1:0];
			// ignored while a transfer runs or is about to
			o_start <= wr && (addr == REG_CTRL) && !i_busy && !o_start;
			// zero length finishes right at the start
			if (o_start)
				done_q <= (o_len == '0);
			else if (busy_q && !i_busy)
				done_q <= 1'b1;
		end
	end

	// ack one cycle after the strobe
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			ack_q <= 1'b0;
		else
			ack_q <= i_req.stb;
	end

	// readback
	always_ff @(posedge i_clk)
	begin
		if (rd)
		begin
			rd_data_q <= '0;
			case (addr)
			REG_SRC:  rd_data_q[WORD_AW-1:0] <= o_src;
			REG_DST:  rd_data_q[WORD_AW-1:0] <= o_dst;
			REG_LEN:  rd_data_q[LEN_WIDTH-1:0] <= o_len;
			REG_CTRL: rd_data_q[1:0] <= {done_q, i_busy};
			default:  rd_data_q <= '0;
			endcase
		end
	end

	assign o_rsp.ack  = ack_q;
	assign o_rsp.data = rd_data_q;

endmodule

/* dma_test_top.sv */
// DMA test subsystem top level
// host drives the DMA registers and the checker status port

`timescale 1ns/10ps

module dma_test_top
	import dma_pkg::*;
(
	input  logic    i_clk,
	input  logic    i_reset,
	input  hb_req_t i_reg_req,
	output hb_rsp_t o_reg_rsp,
	input  hb_req_t i_chk_req,
	output hb_rsp_t o_chk_rsp
);

	// register block to mover
	logic start;
	logic busy;
	logic [WORD_AW-1:0] src;
	logic [WORD_AW-1:0] dst;
	logic [LEN_WIDTH-1:0] len;

	// data bus
	wb_req_t mv_req;
	wb_rsp_t mv_rsp;
	wb_req_t ram_req;
	wb_rsp_t ram_rsp;
	wb_req_t chk_req;
	wb_rsp_t chk_rsp;

	dma_regs u_regs (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_req   (i_reg_req),
		.o_rsp   (o_reg_rsp),
		.o_start (start),
		.o_src   (src),
		.o_dst   (dst),
		.o_len   (len),
		.i_busy  (busy)
	);

	dma_mover u_mover (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_start (start),
		.i_src   (src),
		.i_dst   (dst),
		.i_len   (len),
		.o_busy  (busy),
		.o_req   (mv_req),
		.i_rsp   (mv_rsp)
	);

	bus_slave_mux u_mux (
		.i_req     (mv_req),
		.o_rsp     (mv_rsp),
		.o_ram_req (ram_req),
		.i_ram_rsp (ram_rsp),
		.o_chk_req (chk_req),
		.i_chk_rsp (chk_rsp)
	);

	scratch_ram u_ram (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_req   (ram_req),
		.o_rsp   (ram_rsp)
	);

	lfsr_checker u_checker (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_wb_req (chk_req),
		.o_wb_rsp (chk_rsp),
		.i_st_req (i_chk_req),
		.o_st_rsp (o_chk_rsp)
	);

endmodule

/* tb_lfsr_model.svh */
// reference model of the checker pattern stream, for the testbench only
// included inside the testbench module, after the dma_pkg import

`ifndef TB_LFSR_MODEL_SVH
`define TB_LFSR_MODEL_SVH

// 32 single shifts, feedback from the two top bits
function automatic logic [LFSR_WIDTH-1:0] shift_by_32(input logic [LFSR_WIDTH-1:0] s);
	logic [LFSR_WIDTH-1:0] r;
	logic fb;
	int n;
	r = s;
	for (n = 0; n < 32; n++)
	begin
		fb = r[LFSR_WIDTH-1] ^ r[LFSR_WIDTH-2];
		r = {r[LFSR_WIDTH-2:0], fb};
	end
	return r;
endfunction

// state after a number of words, 64 shifts per word
function automatic logic [LFSR_WIDTH-1:0] state_after_words(input logic [LFSR_WIDTH-1:0] s,
	input int words);
	logic [LFSR_WIDTH-1:0] r;
	int w;
	r = s;
	for (w = 0; w < words; w++)
		r = shift_by_32(shift_by_32(r));
	return r;
endfunction

// word seen at a state: state on top, 32 shifts later below
function automatic logic [63:0] stream_word(input logic [LFSR_WIDTH-1:0] s);
	return {s, shift_by_32(s)};
endfunction

`endif

/* tb_dma_test.sv */
// testbench for the DMA test subsystem
// drives both host ports, copies blocks between checker and RAM
// and checks counts, flags and LFSR state against a reference model

`timescale 1ns/10ps

module tb_dma_test
	import dma_pkg::*;
;

	localparam int ACK_LIMIT = 8;
	localparam int DONE_POLLS = 100;
	localparam logic [WORD_AW-1:0] CHK_BASE = 10'h200;

	logic i_clk = 1'b0;
	logic i_reset;
	hb_req_t reg_req;
	hb_rsp_t reg_rsp;
	hb_req_t chk_req;
	hb_rsp_t chk_rsp;

	integer seed = 32'h3c1bf759;
	int errors = 0;
	logic busy_prev = 1'b0;
	int busy_falls = 0;

	`include "tb_lfsr_model.svh"

	dma_test_top i_dut (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_reg_req (reg_req),
		.o_reg_rsp (reg_rsp),
		.i_chk_req (chk_req),
		.o_chk_rsp (chk_rsp)
	);

	// 40 ns period
	always #20 i_clk = ~i_clk;

	// end of each transfer, seen on the mover busy line
	always @(posedge i_clk)
	begin
		busy_prev <= i_dut.busy;
		if (busy_prev && !i_dut.busy)
			busy_falls <= busy_falls + 1;
	end

	//////////////////////////////
	// checks and host access
	//////////////////////////////

	task automatic check_equal(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		assert (act === exp)
		else
		begin
			$display("error: %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	// one strobe cycle, then wait for the ack, read data comes with it
	task automatic host_access(input bit to_chk, input bit we, input logic [1:0] addr,
		input logic [31:0] data, input logic [3:0] sel, output logic [31:0] rdata);
		hb_req_t req;
		int waited;
		bit got_ack;
		req.stb  = 1'b1;
		req.we   = we;
		req.addr = addr;
		req.data = data;
		req.sel  = sel;
		@(posedge i_clk);
		if (to_chk)
			chk_req <= req;
		else
			reg_req <= req;
		@(posedge i_clk);
		if (to_chk)
			chk_req.stb <= 1'b0;
		else
			reg_req.stb <= 1'b0;
		waited = 0;
		got_ack = 1'b0;
		rdata = '0;
		while (!got_ack && waited < ACK_LIMIT)
		begin
			got_ack = to_chk ? chk_rsp.ack : reg_rsp.ack;
			rdata = to_chk ? chk_rsp.data : reg_rsp.data;
			if (!got_ack)
			begin
				@(posedge i_clk);
				waited++;
			end
		end
		if (!got_ack)
		begin
			$display("host port gave no ack after a strobe");
			errors++;
		end
	endtask

	task automatic write_reg(input dma_reg_e r, input logic [31:0] d);
		logic [31:0] unused;
		host_access(1'b0, 1'b1, r, d, 4'hf, unused);
	endtask

	task automatic read_reg(input dma_reg_e r, output logic [31:0] v);
		host_access(1'b0, 1'b0, r, '0, 4'hf, v);
	endtask

	task automatic write_seed(input logic [31:0] d, input logic [3:0] sel);
		logic [31:0] unused;
		host_access(1'b1, 1'b1, 2'd0, d, sel, unused);
	endtask

	task automatic read_status(input logic [1:0] a, output logic [31:0] v);
		host_access(1'b1, 1'b0, a, '0, 4'hf, v);
	endtask

	// status layout: write bytes 31..20, read bytes 15..4, error bit 0
	function automatic logic [31:0] status_word(input logic [11:0] wr_bytes,
		input logic [11:0] rd_bytes, input bit err);
		return {wr_bytes, 4'h0, rd_bytes, 3'h0, err};
	endfunction

	// poll the done bit
	task automatic wait_done();
		logic [31:0] ctrl;
		int polls;
		ctrl = '0;
		polls = 0;
		while (!ctrl[1] && polls < DONE_POLLS)
		begin
			read_reg(REG_CTRL, ctrl);
			polls++;
		end
		if (!ctrl[1])
		begin
			$display("timed out waiting for the DMA transfer to finish");
			errors++;
		end
	endtask

	task automatic run_copy(input logic [31:0] src, input logic [31:0] dst, input int len);
		write_reg(REG_SRC, src);
		write_reg(REG_DST, dst);
		write_reg(REG_LEN, len);
		write_reg(REG_CTRL, 32'h1);
		wait_done();
	endtask

	//////////////////////////////
	// scenarios
	//////////////////////////////

	initial
	begin
		logic [31:0] v;
		logic [31:0] seed_a;
		logic [31:0] seed_b;
		logic [31:0] mixed;
		logic [LFSR_WIDTH-1:0] st;
		int len;
		int falls_before;
		i_reset = 1'b1;
		reg_req = '0;
		chk_req = '0;
		repeat (3) @(posedge i_clk);
		i_reset <= 1'b0;

		// clean state out of reset
		read_reg(REG_CTRL, v);
		check_equal("reset ctrl", 64'd0, v[1:0]);
		read_status(2'd0, v);
		check_equal("reset status", 64'd0, v);
		read_status(2'd1, v);
		check_equal("reset lfsr state", 64'd0, v);

		// full seed, then bytes 0 and 2 only
		seed_a = $random(seed);
		if (seed_a == '0)
			seed_a = 32'h1;
		write_seed(seed_a, 4'hf);
		read_status(2'd1, v);
		check_equal("seed readback", seed_a, v);
		mixed = $random(seed);
		write_seed(mixed, 4'b0101);
		read_status(2'd1, v);
		check_equal("partial seed",
			{seed_a[31:24], mixed[23:16], seed_a[15:8], mixed[7:0]}, v);

		// checker to ram
		len = 1 + ({$random(seed)} % 16);
		write_seed(seed_a, 4'hf);
		run_copy(CHK_BASE, 0, len);
		read_reg(REG_CTRL, v);
		check_equal("copy out ctrl", 64'd2, v[1:0]);
		read_status(2'd0, v);
		check_equal("copy out status", status_word(0, 8 * len, 1'b0), v);
		read_status(2'd1, v);
		check_equal("copy out lfsr state", state_after_words(seed_a, len), v);
		st = seed_a;
		for (int k = 0; k < len; k++)
		begin
			check_equal("ram word", stream_word(st), i_dut.u_ram.mem[k]);
			st = state_after_words(st, 1);
		end

		// same seed, ram back to checker, no mismatch
		write_seed(seed_a, 4'hf);
		run_copy(0, CHK_BASE, len);
		read_status(2'd0, v);
		check_equal("copy back status", status_word(8 * len, 0, 1'b0), v);

		// other seed, the stream no longer matches
		seed_b = $random(seed);
		if (seed_b == seed_a)
			seed_b = ~seed_a;
		write_seed(seed_b, 4'hf);
		run_copy(0, CHK_BASE, len);
		read_status(2'd0, v);
		check_equal("mismatch status", status_word(8 * len, 0, 1'b1), v);
		write_seed(seed_b, 4'hf);
		read_status(2'd0, v);
		check_equal("status after reseed", 64'd0, v);

		// second start while busy is dropped
		write_seed(seed_a, 4'hf);
		falls_before = busy_falls;
		write_reg(REG_SRC, CHK_BASE);
		write_reg(REG_DST, 32'd32);
		write_reg(REG_LEN, 32'd8);
		write_reg(REG_CTRL, 32'h1);
		read_reg(REG_CTRL, v);
		check_equal("busy after start", 64'd1, v[0]);
		write_reg(REG_CTRL, 32'h1);
		wait_done();
		read_reg(REG_CTRL, v);
		check_equal("ctrl after double start", 64'd2, v[1:0]);
		check_equal("transfers finished", 64'd1, busy_falls - falls_before);
		read_status(2'd0, v);
		check_equal("double start status", status_word(0, 64, 1'b0), v);
		read_status(2'd1, v);
		check_equal("double start lfsr state", state_after_words(seed_a, 8), v);

		$display("checks done, %0d errors", errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* project.f */
+incdir+.
dma_pkg.sv
lfsr_checker.sv
scratch_ram.sv
bus_slave_mux.sv
dma_mover.sv
dma_regs.sv
dma_test_top.sv
tb_dma_test.sv

/* Bender.yml */
package:
  name: dma_test

sources:
  - files:
      - dma_pkg.sv
      - lfsr_checker.sv
      - scratch_ram.sv
      - bus_slave_mux.sv
      - dma_mover.sv
      - dma_regs.sv
      - dma_test_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_dma_test.sv
